/* logic/demo_decode.sv */
module demo_decode (
  input  logic             clk,
  input  logic             rstn,
  input  logic             start,
  input  rtttl_pkg::demo_e demo,
  output logic             play,
  output logic             restart,
  output song_pkg::song_e  song
);
  import rtttl_pkg::*;
  import song_pkg::*;

  logic  valid;
  song_e req_song;

  // only the two song codes start playback
  assign valid = start && ((demo == DEMO_A) || (demo == DEMO_B));
  assign req_song = (demo == DEMO_B) ? SONG_B : SONG_A;

  assign play = valid;
  // same song again keeps its position
  assign restart = valid && (req_song != song);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      song <= SONG_A;
    end else if (valid) begin
      song <= req_song;
    end
  end

endmodule

/* logic/note_sequencer.sv */
module note_sequencer #(
  parameter int TICK_MAX = rtttl_pkg::tick_max_default
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          play,
  input  logic                          restart,
  input  logic [song_pkg::oct_w-1:0]    rom_octave,
  input  logic [song_pkg::note_w-1:0]   rom_note,
  input  logic [rtttl_pkg::dur_w-1:0]   rom_dur,
  input  logic                          rom_end,
  output logic [rtttl_pkg::addr_w-1:0]  address,
  output logic [song_pkg::oct_w-1:0]    octave,
  output logic [song_pkg::note_w-1:0]   note
);
  import rtttl_pkg::*;
  import song_pkg::*;

  logic [tick_w-1:0] tick_cnt;
  logic              tick;
  seq_state_e        state;
  logic [dur_w-1:0]  remaining;

  // free running from reset and wrapping every TICK_MAX+1 cycles
  assign tick = (tick_cnt == tick_w'(TICK_MAX));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= SEQ_IDLE;
      address   <= '0;
      remaining <= '0;
      octave    <= '0;
      note      <= note_reset;
    end else if (restart) begin
      // entry 0 of the new song loads on the next tick
      state     <= SEQ_PLAY;
      address   <= '0;
      remaining <= '0;
    end else begin
      if (tick && (state == SEQ_PLAY)) begin
        if (remaining != '0) begin
          remaining <= remaining - 1'b1;
        end else if (rom_end) begin
          state     <= SEQ_IDLE;
          address   <= '0;
          remaining <= '0;
          octave    <= '0;
          note      <= '0;
        end else begin
          remaining <= rom_dur;
          octave    <= rom_octave;
          note      <= rom_note;
          address   <= address + 1'b1;
        end
      end
      // a start landing on the final tick still wins
      if (play) begin
        state <= SEQ_PLAY;
      end
    end
  end

endmodule

/* logic/rtttl_pkg.sv */
package rtttl_pkg;

  // 1/64 note at the real clock rate
  localparam int tick_max_default = 23810;

  localparam int tick_w = 16;
  localparam int dur_w = 6;
  localparam int addr_w = 8;

  // demo select code from the pins
  typedef enum logic [1:0] {
    DEMO_NONE = 2'b00,
    DEMO_A    = 2'b01,
    DEMO_B    = 2'b10,
    DEMO_BAD  = 2'b11
  } demo_e;

  typedef enum logic {
    SEQ_IDLE = 1'b0,
    SEQ_PLAY = 1'b1
  } seq_state_e;

endpackage

/* logic/rtttl_player.sv */
module rtttl_player #(
  parameter int TICK_MAX = rtttl_pkg::tick_max_default
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         start,
  input  rtttl_pkg::demo_e             demo,
  output logic [song_pkg::oct_w-1:0]   octave,
  output logic [song_pkg::note_w-1:0]  note
);
  import rtttl_pkg::*;
  import song_pkg::*;

  logic              play;
  logic              restart;
  song_e             song;
  logic [addr_w-1:0] address;
  logic [oct_w-1:0]  rom_octave;
  logic [note_w-1:0] rom_note;
  logic [dur_w-1:0]  rom_dur;
  logic              rom_end;

  demo_decode u_decode (
    .clk     (clk),
    .rstn    (rstn),
    .start   (start),
    .demo    (demo),
    .play    (play),
    .restart (restart),
    .song    (song)
  );

  note_sequencer #(
    .TICK_MAX (TICK_MAX)
  ) u_seq (
    .clk        (clk),
    .rstn       (rstn),
    .play       (play),
    .restart    (restart),
    .rom_octave (rom_octave),
    .rom_note   (rom_note),
    .rom_dur    (rom_dur),
    .rom_end    (rom_end),
    .address    (address),
    .octave     (octave),
    .note       (note)
  );

  song_rom u_rom (
    .song       (song),
    .address    (address),
    .rom_octave (rom_octave),
    .rom_note   (rom_note),
    .rom_dur    (rom_dur),
    .rom_end    (rom_end)
  );

endmodule

/* logic/song_pkg.sv */
package song_pkg;

  typedef enum logic {
    SONG_A = 1'b0,
    SONG_B = 1'b1
  } song_e;

  // number of table entries per song
  localparam int song_a_len = 67;
  localparam int song_b_len = 62;

  localparam int oct_w = 4;
  localparam int note_w = 4;

  // note value before anything has played
  localparam logic [note_w-1:0] note_reset = 4'd15;

endpackage

/* logic/song_rom.sv */
module song_rom (
  input  song_pkg::song_e                song,
  input  logic [rtttl_pkg::addr_w-1:0]   address,
  output logic [song_pkg::oct_w-1:0]     rom_octave,
  output logic [song_pkg::note_w-1:0]    rom_note,
  output logic [rtttl_pkg::dur_w-1:0]    rom_dur,
  output logic                           rom_end
);
  import rtttl_pkg::*;
  import song_pkg::*;

  // entries packed as {octave, note, duration}
  logic [oct_w+note_w+dur_w-1:0] a_entry;
  logic [oct_w+note_w+dur_w-1:0] b_entry;

  // scale melody
  always_comb begin
    case (address)
      0:  a_entry = {4'd4, 4'd7, 6'd16};
      1:  a_entry = {4'd4, 4'd9, 6'd16};
      2:  a_entry = {4'd4, 4'd11, 6'd16};
      3:  a_entry = {4'd6, 4'd0, 6'd16};
      4:  a_entry = {4'd6, 4'd2, 6'd16};
      5:  a_entry = {4'd6, 4'd4, 6'd16};
      6:  a_entry = {4'd6, 4'd5, 6'd16};
      7:  a_entry = {4'd6, 4'd7, 6'd8};
      8:  a_entry = {4'd4, 4'd0, 6'd8};
      9:  a_entry = {4'd6, 4'd0, 6'd8};
      10: a_entry = {4'd4, 4'd4, 6'd8};
      11: a_entry = {4'd4, 4'd5, 6'd8};
      12: a_entry = {4'd7, 4'd0, 6'd8};
      13: a_entry = {4'd4, 4'd7, 6'd8};
      14: a_entry = {4'd6, 4'd9, 6'd8};
      15: a_entry = {4'd6, 4'd7, 6'd8};
      16: a_entry = {4'd4, 4'd0, 6'd8};
      17: a_entry = {4'd6, 4'd0, 6'd8};
      18: a_entry = {4'd4, 4'd4, 6'd8};
      19: a_entry = {4'd4, 4'd5, 6'd8};
      20: a_entry = {4'd6, 4'd7, 6'd8};
      21: a_entry = {4'd4, 4'd7, 6'd8};
      22: a_entry = {4'd6, 4'd5, 6'd8};
      23: a_entry = {4'd6, 4'd4, 6'd8};
      24: a_entry = {4'd6, 4'd4, 6'd8};
      25: a_entry = {4'd6, 4'd5, 6'd8};
      26: a_entry = {4'd6, 4'd7, 6'd8};
      27: a_entry = {4'd6, 4'd0, 6'd8};
      28: a_entry = {4'd4, 4'd5, 6'd8};
      29: a_entry = {4'd6, 4'd2, 6'd8};
      30: a_entry = {4'd4, 4'd7, 6'd8};
      31: a_entry = {4'd6, 4'd4, 6'd8};
      32: a_entry = {4'd4, 4'd0, 6'd8};
      33: a_entry = {4'd4, 4'd4, 6'd4};
      34: a_entry = {4'd4, 4'd5, 6'd16};
      35: a_entry = {4'd4, 4'd7, 6'd16};
      36: a_entry = {4'd4, 4'd9, 6'd16};
      37: a_entry = {4'd4, 4'd11, 6'd16};
      38: a_entry = {4'd6, 4'd0, 6'd16};
      39: a_entry = {4'd6, 4'd2, 6'd16};
      40: a_entry = {4'd6, 4'd4, 6'd16};
      41: a_entry = {4'd6, 4'd5, 6'd16};
      42: a_entry = {4'd6, 4'd7, 6'd8};
      43: a_entry = {4'd4, 4'd0, 6'd8};
      44: a_entry = {4'd6, 4'd0, 6'd8};
      45: a_entry = {4'd4, 4'd4, 6'd8};
      46: a_entry = {4'd4, 4'd5, 6'd8};
      47: a_entry = {4'd7, 4'd0, 6'd8};
      48: a_entry = {4'd4, 4'd7, 6'd8};
      49: a_entry = {4'd6, 4'd9, 6'd8};
      50: a_entry = {4'd6, 4'd7, 6'd8};
      51: a_entry = {4'd4, 4'd0, 6'd8};
      52: a_entry = {4'd6, 4'd0, 6'd8};
      53: a_entry = {4'd4, 4'd4, 6'd8};
      54: a_entry = {4'd4, 4'd5, 6'd8};
      55: a_entry = {4'd6, 4'd7, 6'd8};
      56: a_entry = {4'd4, 4'd7, 6'd8};
      57: a_entry = {4'd6, 4'd5, 6'd8};
      58: a_entry = {4'd6, 4'd4, 6'd8};
      59: a_entry = {4'd6, 4'd4, 6'd8};
      60: a_entry = {4'd6, 4'd5, 6'd8};
      61: a_entry = {4'd6, 4'd7, 6'd8};
      62: a_entry = {4'd6, 4'd0, 6'd8};
      63: a_entry = {4'd4, 4'd5, 6'd8};
      64: a_entry = {4'd6, 4'd2, 6'd8};
      65: a_entry = {4'd4, 4'd7, 6'd8};
      66: a_entry = {4'd6, 4'd0, 6'd4};
      default: a_entry = '0;
    endcase
  end

  // second melody with eighth-length entries only
  always_comb begin
    case (address)
      0:  b_entry = {4'd5, 4'd6, 6'd8};
      1:  b_entry = {4'd5, 4'd6, 6'd8};
      2:  b_entry = {4'd5, 4'd6, 6'd8};
      3:  b_entry = {4'd5, 4'd2, 6'd8};
      4:  b_entry = {4'd4, 4'd12, 6'd8};
      5:  b_entry = {4'd4, 4'd11, 6'd8};
      6:  b_entry = {4'd4, 4'd12, 6'd8};
      7:  b_entry = {4'd5, 4'd4, 6'd8};
      8:  b_entry = {4'd4, 4'd12, 6'd8};
      9:  b_entry = {4'd5, 4'd4, 6'd8};
      10: b_entry = {4'd4, 4'd12, 6'd8};
      11: b_entry = {4'd5, 4'd4, 6'd8};
      12: b_entry = {4'd5, 4'd8, 6'd8};
      13: b_entry = {4'd5, 4'd8, 6'd8};
      14: b_entry = {4'd5, 4'd9, 6'd8};
      15: b_entry = {4'd5, 4'd11, 6'd8};
      16: b_entry = {4'd5, 4'd9, 6'd8};
      17: b_entry = {4'd5, 4'd9, 6'd8};
      18: b_entry = {4'd5, 4'd9, 6'd8};
      19: b_entry = {4'd5, 4'd4, 6'd8};
      20: b_entry = {4'd4, 4'd12, 6'd8};
      21: b_entry = {4'd5, 4'd2, 6'd8};
      22: b_entry = {4'd4, 4'd12, 6'd8};
      23: b_entry = {4'd5, 4'd6, 6'd8};
      24: b_entry = {4'd4, 4'd12, 6'd8};
      25: b_entry = {4'd5, 4'd6, 6'd8};
      26: b_entry = {4'd4, 4'd12, 6'd8};
      27: b_entry = {4'd5, 4'd6, 6'd8};
      28: b_entry = {4'd5, 4'd4, 6'd8};
      29: b_entry = {4'd5, 4'd4, 6'd8};
      30: b_entry = {4'd5, 4'd6, 6'd8};
      31: b_entry = {4'd5, 4'd4, 6'd8};
      32: b_entry = {4'd5, 4'd6, 6'd8};
      33: b_entry = {4'd5, 4'd6, 6'd8};
      34: b_entry = {4'd5, 4'd6, 6'd8};
      35: b_entry = {4'd5, 4'd2, 6'd8};
      36: b_entry = {4'd4, 4'd12, 6'd8};
      37: b_entry = {4'd4, 4'd11, 6'd8};
      38: b_entry = {4'd4, 4'd12, 6'd8};
      39: b_entry = {4'd5, 4'd4, 6'd8};
      40: b_entry = {4'd4, 4'd12, 6'd8};
      41: b_entry = {4'd5, 4'd4, 6'd8};
      42: b_entry = {4'd4, 4'd12, 6'd8};
      43: b_entry = {4'd5, 4'd4, 6'd8};
      44: b_entry = {4'd5, 4'd8, 6'd8};
      45: b_entry = {4'd5, 4'd8, 6'd8};
      46: b_entry = {4'd5, 4'd9, 6'd8};
      47: b_entry = {4'd5, 4'd11, 6'd8};
      48: b_entry = {4'd5, 4'd9, 6'd8};
      49: b_entry = {4'd5, 4'd9, 6'd8};
      50: b_entry = {4'd5, 4'd9, 6'd8};
      51: b_entry = {4'd5, 4'd4, 6'd8};
      52: b_entry = {4'd4, 4'd12, 6'd8};
      53: b_entry = {4'd5, 4'd2, 6'd8};
      54: b_entry = {4'd4, 4'd12, 6'd8};
      55: b_entry = {4'd5, 4'd6, 6'd8};
      56: b_entry = {4'd4, 4'd12, 6'd8};
      57: b_entry = {4'd5, 4'd6, 6'd8};
      58: b_entry = {4'd4, 4'd12, 6'd8};
      59: b_entry = {4'd5, 4'd6, 6'd8};
      60: b_entry = {4'd5, 4'd4, 6'd8};
      61: b_entry = {4'd5, 4'd4, 6'd8};
      default: b_entry = '0;
    endcase
  end

  assign {rom_octave, rom_note, rom_dur} = (song == SONG_B) ? b_entry : a_entry;

  // past the last entry of the selected song
  assign rom_end = (song == SONG_B) ? (address >= addr_w'(song_b_len)) :
                                      (address >= addr_w'(song_a_len));

endmodule

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module rtttl_tb \
  -Mdir obj_dir -f vlog.f \
  && ./obj_dir/Vrtttl_tb +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* verification/rtttl_player_sva.sv */
module rtttl_player_sva #(
  parameter int TICK_MAX = rtttl_pkg::tick_max_default
) (
  input logic                        clk,
  input logic                        rstn,
  input logic                        start,
  input rtttl_pkg::demo_e            demo,
  input logic                        play,
  input logic                        restart,
  input logic [song_pkg::oct_w-1:0]  octave,
  input logic [song_pkg::note_w-1:0] note
);
  timeunit 1ns;
  timeprecision 100ps;
  import rtttl_pkg::*;
  import song_pkg::*;

  int                fail_count = 0;
  logic [tick_w-1:0] phase;
  logic              tick_cycle;
  logic              after_tick;
  logic              valid_start;
  logic              switch_req;
  logic              at_home;
  logic              played;
  logic              stopped;
  logic              first_pending;
  song_e             held_song;
  song_e             req_song;
  logic [oct_w-1:0]  first_oct;
  logic [note_w-1:0] first_note;
  logic [oct_w-1:0]  prev_oct;
  logic [note_w-1:0] prev_note;

  // first tick lands TICK_MAX cycles after reset release
  assign tick_cycle = (phase == tick_w'(TICK_MAX));
  assign valid_start = start && ((demo == DEMO_A) || (demo == DEMO_B));
  assign req_song = (demo == DEMO_B) ? SONG_B : SONG_A;
  assign switch_req = valid_start && (req_song != held_song);
  // position is entry 0 before any play and after an end
  assign at_home = (octave == '0) && ((note == note_reset) || (note == '0));

  always_ff @(posedge clk) begin
    prev_oct  <= octave;
    prev_note <= note;
    if (!rstn) begin
      phase         <= '0;
      after_tick    <= 1'b0;
      played        <= 1'b0;
      stopped       <= 1'b0;
      first_pending <= 1'b0;
      held_song     <= SONG_A;
    end else begin
      phase      <= tick_cycle ? '0 : phase + tick_w'(1);
      after_tick <= tick_cycle;
      if (valid_start) begin
        played    <= 1'b1;
        held_song <= req_song;
        stopped   <= 1'b0;
      end else if ((octave == '0) && (note == '0) &&
                   !((prev_oct == '0) && (prev_note == '0))) begin
        // latched when the outputs first fall to 0/0
        stopped <= 1'b1;
      end
      // entry 0 is 4/7 for song A and 5/6 for song B
      if (valid_start && (at_home || switch_req)) begin
        first_pending <= 1'b1;
        first_oct     <= (req_song == SONG_B) ? 4'd5 : 4'd4;
        first_note    <= (req_song == SONG_B) ? 4'd6 : 4'd7;
      end else if (tick_cycle) begin
        first_pending <= 1'b0;
      end
    end
  end

  a_reset_hold: assert property (@(posedge clk) disable iff (!rstn)
    !played |-> (octave == '0) && (note == note_reset))
    else begin
      fail_count++;
      $error("Fail octave/note: got %h/%h before any start, expected 0/%h",
             octave, note, note_reset);
    end

  a_decode: assert property (@(posedge clk) disable iff (!rstn)
    (play == valid_start) && (restart == switch_req))
    else begin
      fail_count++;
      $error("Fail play/restart: got %h/%h, expected %h/%h",
             play, restart, valid_start, switch_req);
    end

  a_on_tick: assert property (@(posedge clk) disable iff (!rstn)
    !after_tick |-> (octave == prev_oct) && (note == prev_note))
    else begin
      fail_count++;
      $error("Fail octave/note: changed from %h/%h to %h/%h off a tick",
             prev_oct, prev_note, octave, note);
    end

  a_first_entry: assert property (@(posedge clk) disable iff (!rstn)
    first_pending && tick_cycle && !valid_start |=>
      (octave == first_oct) && (note == first_note))
    else begin
      fail_count++;
      $error("Fail octave/note: got %h/%h on first tick after start, expected %h/%h",
             octave, note, first_oct, first_note);
    end

  a_end_hold: assert property (@(posedge clk) disable iff (!rstn)
    stopped |-> (octave == '0) && (note == '0))
    else begin
      fail_count++;
      $error("Fail octave/note: got %h/%h after the song ended, expected 0/0", octave, note);
    end

endmodule

bind rtttl_player rtttl_player_sva #(
  .TICK_MAX (TICK_MAX)
) u_sva (
  .clk     (clk),
  .rstn    (rstn),
  .start   (start),
  .demo    (demo),
  .play    (play),
  .restart (restart),
  .octave  (octave),
  .note    (note)
);

/* verification/rtttl_tb.sv */
module rtttl_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rtttl_pkg::*;
  import song_pkg::*;

  localparam int tick_max = 7;
  localparam int clk_ns = 4;
  // one play of the longer song if every entry lasted 16+1 ticks
  localparam int play_cycles = song_a_len * 17 * (tick_max + 1);
  // about four plays in the run plus ample margin
  localparam int watchdog_ns = 11 * play_cycles * clk_ns;
  localparam int first_limit = 2 * (tick_max + 1);

  logic              clk;
  logic              rstn;
  logic              start;
  demo_e             demo;
  logic [oct_w-1:0]  octave;
  logic [note_w-1:0] note;
  int                other_errors;
  int                errors_seen;
  int                tests_run;
  int                tests_failed;

  tb_clock u_clock (
    .clk  (clk),
    .rstn (rstn)
  );

  rtttl_player #(
    .TICK_MAX (tick_max)
  ) DUT (
    .clk    (clk),
    .rstn   (rstn),
    .start  (start),
    .demo   (demo),
    .octave (octave),
    .note   (note)
  );

  task automatic issue_start(input demo_e code);
    @(posedge clk);
    start <= 1'b1;
    demo  <= code;
    @(posedge clk);
    start <= 1'b0;
    demo  <= DEMO_NONE;
  endtask

  task automatic idle_gap(input int lo, input int hi);
    repeat ($urandom_range(hi, lo)) @(posedge clk);
  endtask

  // outputs are sampled on the falling edge away from any update
  task automatic wait_output_change(input string what);
    logic [oct_w-1:0]  last_oct;
    logic [note_w-1:0] last_note;
    int                n;
    @(negedge clk);
    last_oct  = octave;
    last_note = note;
    n = 0;
    while ((octave == last_oct) && (note == last_note) && (n < first_limit)) begin
      @(negedge clk);
      n++;
    end
    if ((octave == last_oct) && (note == last_note)) begin
      $display("%s: octave and note did not change within %0d cycles", what, first_limit);
      other_errors++;
    end
  endtask

  task automatic wait_song_end(input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!((octave == '0) && (note == '0)) && (n < play_cycles)) begin
      @(negedge clk);
      n++;
    end
    if (!((octave == '0) && (note == '0))) begin
      $display("%s: song did not end within %0d cycles", what, play_cycles);
      other_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = DUT.u_sva.fail_count + other_errors - errors_seen;
    errors_seen += errs;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s, %0d errors", tests_run, name,
             (errs == 0) ? "ok" : "failed", errs);
  endtask

  initial begin
    start = 1'b0;
    demo = DEMO_NONE;
    other_errors = 0;
    errors_seen = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(53));
    wait (rstn == 1'b1);
    idle_gap(10, 30);
    finish_test("reset values");
    repeat (4) begin
      issue_start(($urandom_range(1, 0) == 0) ? DEMO_NONE : DEMO_BAD);
      idle_gap(3, 12);
    end
    finish_test("invalid codes");
    issue_start(DEMO_A);
    wait_output_change("first note A");
    finish_test("first note A");
    wait_song_end("tick alignment");
    finish_test("tick alignment");
    idle_gap(20, 60);
    issue_start(DEMO_A);
    wait_output_change("replay after end");
    finish_test("end of song");
    // switch away and back mid-song and finish with a same-song start
    idle_gap(30, 150);
    issue_start(DEMO_B);
    wait_output_change("switch to B");
    idle_gap(30, 120);
    issue_start(DEMO_A);
    wait_output_change("switch to A");
    idle_gap(30, 120);
    issue_start(DEMO_A);
    wait_song_end("song switch");
    finish_test("song switch");
    idle_gap(10, 40);
    issue_start(DEMO_B);
    wait_output_change("first note B");
    wait_song_end("first note B");
    finish_test("first note B");
    $display("%0d tests, %0d failed, %0d assertion errors, %0d other errors",
             tests_run, tests_failed, DUT.u_sva.fail_count, other_errors);
    if (tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, run stopped", watchdog_ns);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
module tb_clock (
  output logic clk,
  output logic rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset held for three rising edges
  initial begin
    rstn = 1'b0;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

/* vlog.f */
logic/rtttl_pkg.sv
logic/song_pkg.sv
logic/demo_decode.sv
logic/song_rom.sv
logic/note_sequencer.sv
logic/rtttl_player.sv
verification/tb_clock.sv
verification/rtttl_player_sva.sv
verification/rtttl_tb.sv
